//--- src/axi_id_ser_pkg.sv
// AXI read ID serializer shared widths and AR/R channel payload structs
package axi_id_ser_pkg;

  // Default widths, passed down from the top level as module parameters
  localparam int unsigned slv_id_width    = 6;
  localparam int unsigned mst_id_width    = 2;
  // Lane count must not exceed 2**mst_id_width
  localparam int unsigned num_uniq_ids    = 4;
  localparam int unsigned max_txns_per_id = 4;
  localparam int unsigned addr_width      = 32;
  localparam int unsigned data_width      = 32;

  typedef logic [slv_id_width-1:0] slv_id_t;
  typedef logic [mst_id_width-1:0] mst_id_t;
  typedef logic [addr_width-1:0]   addr_t;
  typedef logic [data_width-1:0]   data_t;

  // AR payload at the slave port and on the lanes
  typedef struct packed {
    slv_id_t    id;
    addr_t      addr;
    logic [7:0] len;
    logic [2:0] size;
    logic [1:0] burst;
  } ar_chan_t;

  // R payload at the slave port and on the lanes
  typedef struct packed {
    slv_id_t    id;
    data_t      data;
    logic [1:0] resp;
    logic       last;
  } r_chan_t;

  // Narrow master port variants
  typedef struct packed {
    mst_id_t    id;
    addr_t      addr;
    logic [7:0] len;
    logic [2:0] size;
    logic [1:0] burst;
  } mst_ar_chan_t;

  typedef struct packed {
    mst_id_t    id;
    data_t      data;
    logic [1:0] resp;
    logic       last;
  } mst_r_chan_t;

endpackage

//--- src/ar_lane_demux.sv
// AR lane demultiplexer with one spill stage, merges lane R beats back to the slave port
`timescale 1ns/1ps

module ar_lane_demux #(
  parameter int unsigned slv_id_width = axi_id_ser_pkg::slv_id_width,
  parameter int unsigned num_uniq_ids = axi_id_ser_pkg::num_uniq_ids,
  parameter int unsigned addr_width   = axi_id_ser_pkg::addr_width,
  parameter int unsigned data_width   = axi_id_ser_pkg::data_width
) (
  input  logic                                        clk_i,
  input  logic                                        rst_n_i,
  input  axi_id_ser_pkg::ar_chan_t                    slv_ar_i,
  input  logic                                        slv_ar_valid_i,
  output logic                                        slv_ar_ready_o,
  output axi_id_ser_pkg::r_chan_t                     slv_r_o,
  output logic                                        slv_r_valid_o,
  input  logic                                        slv_r_ready_i,
  output axi_id_ser_pkg::ar_chan_t [num_uniq_ids-1:0] lane_ar_o,
  output logic [num_uniq_ids-1:0]                     lane_ar_valid_o,
  input  logic [num_uniq_ids-1:0]                     lane_ar_ready_i,
  input  axi_id_ser_pkg::r_chan_t [num_uniq_ids-1:0]  lane_r_i,
  input  logic [num_uniq_ids-1:0]                     lane_r_valid_i,
  output logic [num_uniq_ids-1:0]                     lane_r_ready_o
);

  localparam int unsigned sel_width = (num_uniq_ids > 1) ? $clog2(num_uniq_ids) : 1;

  logic                    full_q;
  logic [sel_width-1:0]    sel_q;
  logic [sel_width-1:0]    sel_d;
  logic                    lane_hs;

  // Spill register payload
  logic [slv_id_width-1:0] id_q;
  logic [addr_width-1:0]   addr_q;
  logic [7:0]              len_q;
  logic [2:0]              size_q;
  logic [1:0]              burst_q;

  // Merged R beat
  logic [slv_id_width-1:0] r_id;
  logic [data_width-1:0]   r_data;
  logic [1:0]              r_resp;
  logic                    r_last;

  // Lane is the slave ID folded modulo the lane count
  assign sel_d = sel_width'(slv_ar_i.id[slv_id_width-1:0] % num_uniq_ids);

  assign lane_hs        = full_q && lane_ar_ready_i[sel_q];
  assign slv_ar_ready_o = !full_q || lane_hs;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      full_q <= 1'b0;
      sel_q  <= '0;
    end else if (slv_ar_ready_o) begin
      full_q <= slv_ar_valid_i;
      if (slv_ar_valid_i) begin
        sel_q <= sel_d;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (slv_ar_valid_i && slv_ar_ready_o) begin
      id_q    <= slv_ar_i.id[slv_id_width-1:0];
      addr_q  <= slv_ar_i.addr[addr_width-1:0];
      len_q   <= slv_ar_i.len;
      size_q  <= slv_ar_i.size;
      burst_q <= slv_ar_i.burst;
    end
  end

  // Same payload on every lane, only the selected lane sees valid
  always_comb begin
    for (int unsigned i = 0; i < num_uniq_ids; i++) begin
      lane_ar_o[i].id    = id_q;
      lane_ar_o[i].addr  = addr_q;
      lane_ar_o[i].len   = len_q;
      lane_ar_o[i].size  = size_q;
      lane_ar_o[i].burst = burst_q;
      lane_ar_valid_o[i] = full_q && (sel_q == sel_width'(i));
    end
  end

  // The mux forwards one master R at a time, so at most one lane is valid
  always_comb begin
    r_id          = '0;
    r_data        = '0;
    r_resp        = '0;
    r_last        = 1'b0;
    slv_r_valid_o = 1'b0;
    for (int unsigned i = 0; i < num_uniq_ids; i++) begin
      if (lane_r_valid_i[i]) begin
        r_id          = r_id | lane_r_i[i].id[slv_id_width-1:0];
        r_data        = r_data | lane_r_i[i].data[data_width-1:0];
        r_resp        = r_resp | lane_r_i[i].resp;
        r_last        = r_last | lane_r_i[i].last;
        slv_r_valid_o = 1'b1;
      end
    end
  end

  assign slv_r_o.id   = r_id;
  assign slv_r_o.data = r_data;
  assign slv_r_o.resp = r_resp;
  assign slv_r_o.last = r_last;

  assign lane_r_ready_o = {num_uniq_ids{slv_r_ready_i}};

endmodule

//--- src/ar_id_serializer.sv
// Per-lane ID serializer, issues ARs on ID zero and restores the original IDs on R
`timescale 1ns/1ps

module ar_id_serializer #(
  parameter int unsigned max_txns_per_id = axi_id_ser_pkg::max_txns_per_id
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  axi_id_ser_pkg::ar_chan_t in_ar_i,
  input  logic                     in_ar_valid_i,
  output logic                     in_ar_ready_o,
  output axi_id_ser_pkg::r_chan_t  in_r_o,
  output logic                     in_r_valid_o,
  input  logic                     in_r_ready_i,
  output axi_id_ser_pkg::ar_chan_t out_ar_o,
  output logic                     out_ar_valid_o,
  input  logic                     out_ar_ready_i,
  input  axi_id_ser_pkg::r_chan_t  out_r_i,
  input  logic                     out_r_valid_i,
  output logic                     out_r_ready_o
);

  localparam int unsigned ptr_width = (max_txns_per_id > 1) ? $clog2(max_txns_per_id) : 1;
  localparam int unsigned cnt_width = $clog2(max_txns_per_id + 1);
  localparam logic [ptr_width-1:0] last_ptr = ptr_width'(max_txns_per_id - 1);
  localparam logic [cnt_width-1:0] max_cnt  = cnt_width'(max_txns_per_id);

  // Original slave IDs in issue order
  axi_id_ser_pkg::slv_id_t id_mem [max_txns_per_id];

  logic [ptr_width-1:0] wr_ptr_q;
  logic [ptr_width-1:0] rd_ptr_q;
  logic [cnt_width-1:0] count_q;
  logic                 full;
  logic                 push;
  logic                 pop;

  assign full = (count_q == max_cnt);

  // AR path, blocked only while this lane's queue is full
  always_comb begin
    out_ar_o       = in_ar_i;
    out_ar_o.id    = '0;
    out_ar_valid_o = in_ar_valid_i && !full;
    in_ar_ready_o  = out_ar_ready_i && !full;
  end

  // R path, the head of the queue names the burst in flight
  always_comb begin
    in_r_o        = out_r_i;
    in_r_o.id     = id_mem[rd_ptr_q];
    in_r_valid_o  = out_r_valid_i;
    out_r_ready_o = in_r_ready_i;
  end

  assign push = out_ar_valid_o && out_ar_ready_i;
  assign pop  = out_r_valid_i && in_r_ready_i && out_r_i.last;

  always_ff @(posedge clk_i) begin
    if (push) begin
      id_mem[wr_ptr_q] <= in_ar_i.id;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == last_ptr) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == last_ptr) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

//--- src/ar_lane_mux.sv
// Round-robin AR lane multiplexer, lane index becomes the master ID and steers R back
`timescale 1ns/1ps

module ar_lane_mux #(
  parameter int unsigned num_uniq_ids = axi_id_ser_pkg::num_uniq_ids,
  parameter int unsigned mst_id_width = axi_id_ser_pkg::mst_id_width
) (
  input  logic                                        clk_i,
  input  logic                                        rst_n_i,
  input  axi_id_ser_pkg::ar_chan_t [num_uniq_ids-1:0] lane_ar_i,
  input  logic [num_uniq_ids-1:0]                     lane_ar_valid_i,
  output logic [num_uniq_ids-1:0]                     lane_ar_ready_o,
  output axi_id_ser_pkg::r_chan_t [num_uniq_ids-1:0]  lane_r_o,
  output logic [num_uniq_ids-1:0]                     lane_r_valid_o,
  input  logic [num_uniq_ids-1:0]                     lane_r_ready_i,
  output axi_id_ser_pkg::mst_ar_chan_t                mst_ar_o,
  output logic                                        mst_ar_valid_o,
  input  logic                                        mst_ar_ready_i,
  input  axi_id_ser_pkg::mst_r_chan_t                 mst_r_i,
  input  logic                                        mst_r_valid_i,
  output logic                                        mst_r_ready_o
);

  localparam int unsigned idx_width = (num_uniq_ids > 1) ? $clog2(num_uniq_ids) : 1;
  localparam logic [idx_width-1:0] last_idx = idx_width'(num_uniq_ids - 1);

  logic [idx_width-1:0]    ptr_q;
  logic [idx_width-1:0]    grant_idx;
  logic                    grant_valid;
  logic [mst_id_width-1:0] grant_id;
  logic [mst_id_width-1:0] r_sel;

  // First valid lane at or after the pointer
  always_comb begin
    int unsigned idx;
    grant_valid = 1'b0;
    grant_idx   = ptr_q;
    for (int unsigned k = 0; k < num_uniq_ids; k++) begin
      idx = (32'(ptr_q) + k) % num_uniq_ids;
      if (!grant_valid && lane_ar_valid_i[idx]) begin
        grant_valid = 1'b1;
        grant_idx   = idx_width'(idx);
      end
    end
  end

  // Park on a pending grant so its payload stays stable, step past it on transfer
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ptr_q <= '0;
    end else if (grant_valid) begin
      if (mst_ar_ready_i) begin
        ptr_q <= (grant_idx == last_idx) ? '0 : grant_idx + 1'b1;
      end else begin
        ptr_q <= grant_idx;
      end
    end
  end

  assign grant_id = mst_id_width'(grant_idx);

  always_comb begin
    mst_ar_o.id    = grant_id;
    mst_ar_o.addr  = lane_ar_i[grant_idx].addr;
    mst_ar_o.len   = lane_ar_i[grant_idx].len;
    mst_ar_o.size  = lane_ar_i[grant_idx].size;
    mst_ar_o.burst = lane_ar_i[grant_idx].burst;
    mst_ar_valid_o = grant_valid;
    for (int unsigned i = 0; i < num_uniq_ids; i++) begin
      lane_ar_ready_o[i] = grant_valid && mst_ar_ready_i && (grant_idx == idx_width'(i));
    end
  end

  // R beats go back to the lane named by the master ID
  assign r_sel = mst_r_i.id;

  always_comb begin
    mst_r_ready_o = 1'b0;
    for (int unsigned i = 0; i < num_uniq_ids; i++) begin
      lane_r_o[i].id    = '0;
      lane_r_o[i].data  = mst_r_i.data;
      lane_r_o[i].resp  = mst_r_i.resp;
      lane_r_o[i].last  = mst_r_i.last;
      lane_r_valid_o[i] = mst_r_valid_i && (r_sel == mst_id_width'(i));
      if (r_sel == mst_id_width'(i)) begin
        mst_r_ready_o = lane_r_ready_i[i];
      end
    end
  end

endmodule

//--- src/axi_id_serialize_rd.sv
// Read-side AXI ID serializer top, demux into per-lane serializers and merge onto the master port
`timescale 1ns/1ps

module axi_id_serialize_rd #(
  parameter int unsigned slv_id_width    = axi_id_ser_pkg::slv_id_width,
  parameter int unsigned mst_id_width    = axi_id_ser_pkg::mst_id_width,
  parameter int unsigned num_uniq_ids    = axi_id_ser_pkg::num_uniq_ids,
  parameter int unsigned max_txns_per_id = axi_id_ser_pkg::max_txns_per_id,
  parameter int unsigned addr_width      = axi_id_ser_pkg::addr_width,
  parameter int unsigned data_width      = axi_id_ser_pkg::data_width
) (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  axi_id_ser_pkg::ar_chan_t     slv_ar_i,
  input  logic                         slv_ar_valid_i,
  output logic                         slv_ar_ready_o,
  output axi_id_ser_pkg::r_chan_t      slv_r_o,
  output logic                         slv_r_valid_o,
  input  logic                         slv_r_ready_i,
  output axi_id_ser_pkg::mst_ar_chan_t mst_ar_o,
  output logic                         mst_ar_valid_o,
  input  logic                         mst_ar_ready_i,
  input  axi_id_ser_pkg::mst_r_chan_t  mst_r_i,
  input  logic                         mst_r_valid_i,
  output logic                         mst_r_ready_o
);

  // Demux to serializers
  axi_id_ser_pkg::ar_chan_t [num_uniq_ids-1:0] demux_ar;
  logic [num_uniq_ids-1:0]                     demux_ar_valid;
  logic [num_uniq_ids-1:0]                     demux_ar_ready;
  axi_id_ser_pkg::r_chan_t [num_uniq_ids-1:0]  demux_r;
  logic [num_uniq_ids-1:0]                     demux_r_valid;
  logic [num_uniq_ids-1:0]                     demux_r_ready;

  // Serializers to mux
  axi_id_ser_pkg::ar_chan_t [num_uniq_ids-1:0] ser_ar;
  logic [num_uniq_ids-1:0]                     ser_ar_valid;
  logic [num_uniq_ids-1:0]                     ser_ar_ready;
  axi_id_ser_pkg::r_chan_t [num_uniq_ids-1:0]  ser_r;
  logic [num_uniq_ids-1:0]                     ser_r_valid;
  logic [num_uniq_ids-1:0]                     ser_r_ready;

  ar_lane_demux #(
    .slv_id_width ( slv_id_width ),
    .num_uniq_ids ( num_uniq_ids ),
    .addr_width   ( addr_width   ),
    .data_width   ( data_width   )
  ) ar_lane_demux_i (
    .clk_i           ( clk_i          ),
    .rst_n_i         ( rst_n_i        ),
    .slv_ar_i        ( slv_ar_i       ),
    .slv_ar_valid_i  ( slv_ar_valid_i ),
    .slv_ar_ready_o  ( slv_ar_ready_o ),
    .slv_r_o         ( slv_r_o        ),
    .slv_r_valid_o   ( slv_r_valid_o  ),
    .slv_r_ready_i   ( slv_r_ready_i  ),
    .lane_ar_o       ( demux_ar       ),
    .lane_ar_valid_o ( demux_ar_valid ),
    .lane_ar_ready_i ( demux_ar_ready ),
    .lane_r_i        ( demux_r        ),
    .lane_r_valid_i  ( demux_r_valid  ),
    .lane_r_ready_o  ( demux_r_ready  )
  );

  for (genvar i = 0; i < num_uniq_ids; i++) begin : gen_lanes
    ar_id_serializer #(
      .max_txns_per_id ( max_txns_per_id )
    ) ar_id_serializer_i (
      .clk_i          ( clk_i             ),
      .rst_n_i        ( rst_n_i           ),
      .in_ar_i        ( demux_ar[i]       ),
      .in_ar_valid_i  ( demux_ar_valid[i] ),
      .in_ar_ready_o  ( demux_ar_ready[i] ),
      .in_r_o         ( demux_r[i]        ),
      .in_r_valid_o   ( demux_r_valid[i]  ),
      .in_r_ready_i   ( demux_r_ready[i]  ),
      .out_ar_o       ( ser_ar[i]         ),
      .out_ar_valid_o ( ser_ar_valid[i]   ),
      .out_ar_ready_i ( ser_ar_ready[i]   ),
      .out_r_i        ( ser_r[i]          ),
      .out_r_valid_i  ( ser_r_valid[i]    ),
      .out_r_ready_o  ( ser_r_ready[i]    )
    );
  end

  ar_lane_mux #(
    .num_uniq_ids ( num_uniq_ids ),
    .mst_id_width ( mst_id_width )
  ) ar_lane_mux_i (
    .clk_i           ( clk_i          ),
    .rst_n_i         ( rst_n_i        ),
    .lane_ar_i       ( ser_ar         ),
    .lane_ar_valid_i ( ser_ar_valid   ),
    .lane_ar_ready_o ( ser_ar_ready   ),
    .lane_r_o        ( ser_r          ),
    .lane_r_valid_o  ( ser_r_valid    ),
    .lane_r_ready_i  ( ser_r_ready    ),
    .mst_ar_o        ( mst_ar_o       ),
    .mst_ar_valid_o  ( mst_ar_valid_o ),
    .mst_ar_ready_i  ( mst_ar_ready_i ),
    .mst_r_i         ( mst_r_i        ),
    .mst_r_valid_i   ( mst_r_valid_i  ),
    .mst_r_ready_o   ( mst_r_ready_o  )
  );

endmodule

//--- sim/tb_axi_id_serialize.sv
// Testbench for the read-side AXI ID serializer with vector-driven slave port and reordering memory
`timescale 1ns/1ps

module tb_axi_id_serialize;

  localparam int unsigned num_vectors = 26;
  localparam int unsigned num_ids     = axi_id_ser_pkg::num_uniq_ids;
  localparam int unsigned num_slv_ids = 1 << axi_id_ser_pkg::slv_id_width;
  localparam int unsigned max_txns    = axi_id_ser_pkg::max_txns_per_id;
  localparam int unsigned pend_depth  = 8;
  // Memory model withholds every response for this many cycles
  localparam int unsigned hold_cycles = 150;
  localparam int unsigned max_cycles  = 200 * num_vectors + 100;
  // Word-sized incrementing bursts on every request
  localparam logic [2:0]  ar_size     = 3'd2;
  localparam logic [1:0]  ar_burst    = 2'b01;
  localparam int          t_reset     = 0;
  localparam int          t_map       = 1;
  localparam int          t_data      = 2;
  localparam int          t_order     = 3;
  localparam int          t_limit     = 4;
  localparam int          t_bp        = 5;

  logic                         clk_i;
  logic                         rst_n_i;
  axi_id_ser_pkg::ar_chan_t     slv_ar_i;
  logic                         slv_ar_valid_i;
  logic                         slv_ar_ready_o;
  axi_id_ser_pkg::r_chan_t      slv_r_o;
  logic                         slv_r_valid_o;
  logic                         slv_r_ready_i;
  axi_id_ser_pkg::mst_ar_chan_t mst_ar_o;
  logic                         mst_ar_valid_o;
  logic                         mst_ar_ready_i;
  axi_id_ser_pkg::mst_r_chan_t  mst_r_i;
  logic                         mst_r_valid_i;
  logic                         mst_r_ready_o;

  // Four words per vector: slave ID, address, len, expected master ID
  logic [31:0] vec_mem [4*num_vectors];

  // Expected bursts per slave ID and issue order per lane, as vector indices
  int sb_vec [num_slv_ids][num_vectors];
  int sb_head [num_slv_ids];
  int sb_tail [num_slv_ids];
  int sb_beat [num_slv_ids];
  int ar_vec [num_ids][num_vectors];
  int ar_head [num_ids];
  int ar_tail [num_ids];
  int rd_vec [num_ids][num_vectors];
  int rd_head [num_ids];
  int rd_tail [num_ids];

  // Memory model state per master ID
  logic [31:0] pend_addr [num_ids][pend_depth];
  logic [7:0]  pend_len  [num_ids][pend_depth];
  int          pend_head [num_ids];
  int          pend_cnt  [num_ids];
  int          mdl_beat  [num_ids];
  int          peak      [num_ids];

  int                      err_cnt [6];
  string                   test_name [6];
  logic [31:0]             rng;
  int unsigned             cycle;
  int unsigned             drv_idx;
  int unsigned             done_cnt;
  bit                      ar_taken;
  bit                      mr_taken;
  bit                      stalled;
  axi_id_ser_pkg::r_chan_t held_r;

  always #10 clk_i = ~clk_i;

  axi_id_serialize_rd #(
    .slv_id_width    ( axi_id_ser_pkg::slv_id_width    ),
    .mst_id_width    ( axi_id_ser_pkg::mst_id_width    ),
    .num_uniq_ids    ( axi_id_ser_pkg::num_uniq_ids    ),
    .max_txns_per_id ( axi_id_ser_pkg::max_txns_per_id ),
    .addr_width      ( axi_id_ser_pkg::addr_width      ),
    .data_width      ( axi_id_ser_pkg::data_width      )
  ) axi_id_serialize_rd_i (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .slv_ar_i       ( slv_ar_i       ),
    .slv_ar_valid_i ( slv_ar_valid_i ),
    .slv_ar_ready_o ( slv_ar_ready_o ),
    .slv_r_o        ( slv_r_o        ),
    .slv_r_valid_o  ( slv_r_valid_o  ),
    .slv_r_ready_i  ( slv_r_ready_i  ),
    .mst_ar_o       ( mst_ar_o       ),
    .mst_ar_valid_o ( mst_ar_valid_o ),
    .mst_ar_ready_i ( mst_ar_ready_i ),
    .mst_r_i        ( mst_r_i        ),
    .mst_r_valid_i  ( mst_r_valid_i  ),
    .mst_r_ready_o  ( mst_r_ready_o  )
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic int vec_id(input int v);
    return int'(vec_mem[4*v][axi_id_ser_pkg::slv_id_width-1:0]);
  endfunction

  function automatic logic [31:0] vec_addr(input int v);
    return vec_mem[4*v+1];
  endfunction

  function automatic logic [7:0] vec_len(input int v);
    return vec_mem[4*v+2][7:0];
  endfunction

  function automatic int vec_mst(input int v);
    return int'(vec_mem[4*v+3]);
  endfunction

  task automatic check_idle(input string phase);
    if (mst_ar_valid_o !== 1'b0) begin
      $display("[ERROR] reset_state: mst_ar_valid_o %s expected 0 actual %b", phase,
               mst_ar_valid_o);
      err_cnt[t_reset]++;
    end
    if (slv_r_valid_o !== 1'b0) begin
      $display("[ERROR] reset_state: slv_r_valid_o %s expected 0 actual %b", phase,
               slv_r_valid_o);
      err_cnt[t_reset]++;
    end
  endtask

  task automatic report_test(input int t);
    $display("%s %s (%0d errors)", (err_cnt[t] == 0) ? "PASS" : "FAIL", test_name[t],
             err_cnt[t]);
  endtask

  // Master AR against the lane's expected order, then into the memory model
  task automatic take_master_ar();
    int m;
    int v;
    m = int'(mst_ar_o.id);
    if (ar_head[m] == ar_tail[m]) begin
      $display("[ERROR] id_mapping: master AR on ID %0d while no request is expected there", m);
      err_cnt[t_map]++;
    end else begin
      v = ar_vec[m][ar_head[m]];
      ar_head[m]++;
      if (mst_ar_o.addr !== vec_addr(v)) begin
        $display("[ERROR] id_mapping: ID %0d addr expected %h actual %h", m, vec_addr(v),
                 mst_ar_o.addr);
        err_cnt[t_map]++;
      end
      if (mst_ar_o.len !== vec_len(v)) begin
        $display("[ERROR] id_mapping: ID %0d len expected %h actual %h", m, vec_len(v),
                 mst_ar_o.len);
        err_cnt[t_map]++;
      end
    end
    if (mst_ar_o.size !== ar_size) begin
      $display("[ERROR] id_mapping: ID %0d size expected %h actual %h", m, ar_size,
               mst_ar_o.size);
      err_cnt[t_map]++;
    end
    if (mst_ar_o.burst !== ar_burst) begin
      $display("[ERROR] id_mapping: ID %0d burst expected %h actual %h", m, ar_burst,
               mst_ar_o.burst);
      err_cnt[t_map]++;
    end
    if (pend_cnt[m] >= max_txns) begin
      $display("[ERROR] per_lane_limit: ID %0d outstanding expected at most %0d actual %0d", m,
               max_txns, pend_cnt[m] + 1);
      err_cnt[t_limit]++;
    end
    if (pend_cnt[m] < pend_depth) begin
      pend_addr[m][(pend_head[m] + pend_cnt[m]) % pend_depth] = mst_ar_o.addr;
      pend_len[m][(pend_head[m] + pend_cnt[m]) % pend_depth]  = mst_ar_o.len;
      pend_cnt[m]++;
    end
    if (cycle < hold_cycles && pend_cnt[m] > peak[m]) begin
      peak[m] = pend_cnt[m];
    end
  endtask

  task automatic check_slave_r();
    int          s;
    int          v;
    int          b;
    int          l;
    logic [31:0] exp_data;
    s = int'(slv_r_o.id);
    if (sb_head[s] == sb_tail[s]) begin
      $display("[ERROR] id_restore_data: R beat for slave ID %0h which has no burst open", s);
      err_cnt[t_data]++;
      return;
    end
    v = sb_vec[s][sb_head[s]];
    b = sb_beat[s];
    exp_data = vec_addr(v) + 32'(4 * b);
    if (slv_r_o.data !== exp_data) begin
      $display("[ERROR] id_restore_data: ID %0h beat %0d data expected %h actual %h", s, b,
               exp_data, slv_r_o.data);
      err_cnt[t_data]++;
    end
    if (slv_r_o.resp !== 2'(b)) begin
      $display("[ERROR] id_restore_data: ID %0h beat %0d resp expected %h actual %h", s, b,
               2'(b), slv_r_o.resp);
      err_cnt[t_data]++;
    end
    if (slv_r_o.last !== (b == int'(vec_len(v)))) begin
      $display("[ERROR] id_restore_data: ID %0h beat %0d last expected %b actual %b", s, b,
               (b == int'(vec_len(v))), slv_r_o.last);
      err_cnt[t_data]++;
    end
    if (b < int'(vec_len(v))) begin
      sb_beat[s]++;
      return;
    end
    sb_head[s]++;
    sb_beat[s] = 0;
    done_cnt++;
    l = vec_mst(v);
    if (rd_head[l] == rd_tail[l] || rd_vec[l][rd_head[l]] != v) begin
      $display("[ERROR] ordering: lane %0d completed vector expected %0d actual %0d", l,
               rd_vec[l][rd_head[l]], v);
      err_cnt[t_order]++;
    end
    rd_head[l]++;
  endtask

  // Samples every handshake that completes on the coming rising edge
  task automatic monitor_edge();
    int s;
    int l;
    int m;
    ar_taken = slv_ar_valid_i && slv_ar_ready_o;
    mr_taken = mst_r_valid_i && mst_r_ready_o;
    if (ar_taken) begin
      s = vec_id(drv_idx);
      l = vec_mst(drv_idx);
      sb_vec[s][sb_tail[s]] = drv_idx;
      sb_tail[s]++;
      ar_vec[l][ar_tail[l]] = drv_idx;
      ar_tail[l]++;
      rd_vec[l][rd_tail[l]] = drv_idx;
      rd_tail[l]++;
      drv_idx++;
    end
    if (mst_ar_valid_o && mst_ar_ready_i) begin
      take_master_ar();
    end
    if (mr_taken) begin
      m = int'(mst_r_i.id);
      if (mst_r_i.last) begin
        pend_head[m] = (pend_head[m] + 1) % pend_depth;
        pend_cnt[m]--;
        mdl_beat[m] = 0;
      end else begin
        mdl_beat[m]++;
      end
    end
    if (slv_r_valid_o && slv_r_ready_i) begin
      check_slave_r();
    end
    if (stalled && !slv_r_valid_o) begin
      $display("[ERROR] back_pressure: slave R valid dropped before its beat transferred");
      err_cnt[t_bp]++;
    end else if (stalled && slv_r_o !== held_r) begin
      $display("[ERROR] back_pressure: stalled R payload expected %h actual %h", held_r, slv_r_o);
      err_cnt[t_bp]++;
    end
    stalled = slv_r_valid_o && !slv_r_ready_i;
    held_r  = slv_r_o;
  endtask

  task automatic drive_inputs();
    int  start;
    int  m;
    bit  found;
    if (!slv_ar_valid_i || ar_taken) begin
      rng = lcg_next(rng);
      slv_ar_valid_i = (drv_idx < num_vectors) && (rng[31:30] != 2'b00);
      slv_ar_i = '0;
      if (drv_idx < num_vectors) begin
        slv_ar_i.id    = axi_id_ser_pkg::slv_id_t'(vec_id(drv_idx));
        slv_ar_i.addr  = vec_addr(drv_idx);
        slv_ar_i.len   = vec_len(drv_idx);
        slv_ar_i.size  = ar_size;
        slv_ar_i.burst = ar_burst;
      end
    end
    rng = lcg_next(rng);
    mst_ar_ready_i = (rng[31:30] != 2'b00);
    rng = lcg_next(rng);
    slv_r_ready_i = (rng[31:30] != 2'b00);
    // A pending master R beat stays put, otherwise pick the next ID at random
    if (!mst_r_valid_i || mr_taken) begin
      mst_r_valid_i = 1'b0;
      mst_r_i = '0;
      found = 1'b0;
      rng = lcg_next(rng);
      start = int'(rng[31:16] % num_ids);
      for (int k = 0; k < num_ids; k++) begin
        m = (start + k) % num_ids;
        if (cycle >= hold_cycles && !found && pend_cnt[m] > 0) begin
          found = 1'b1;
          mst_r_valid_i = 1'b1;
          mst_r_i.id    = axi_id_ser_pkg::mst_id_t'(m);
          mst_r_i.data  = pend_addr[m][pend_head[m]] + 32'(4 * mdl_beat[m]);
          // Response code follows the beat number so every code crosses the R path
          mst_r_i.resp  = 2'(mdl_beat[m]);
          mst_r_i.last  = (mdl_beat[m] == int'(pend_len[m][pend_head[m]]));
        end
      end
    end
  endtask

  initial begin
    bit load_ok;
    bit timed_out;
    bit reached;
    int n_fail;
    clk_i          = 1'b0;
    rst_n_i        = 1'b0;
    slv_ar_i       = '0;
    slv_ar_valid_i = 1'b0;
    slv_r_ready_i  = 1'b0;
    mst_ar_ready_i = 1'b0;
    mst_r_i        = '0;
    mst_r_valid_i  = 1'b0;
    rng            = 32'h42df;
    cycle          = 0;
    drv_idx        = 0;
    done_cnt       = 0;
    stalled        = 1'b0;
    held_r         = '0;
    timed_out      = 1'b0;
    test_name = '{"reset_state", "id_mapping", "id_restore_data", "ordering",
                  "per_lane_limit", "back_pressure"};
    foreach (err_cnt[t]) err_cnt[t] = 0;
    foreach (sb_head[s]) begin
      sb_head[s] = 0;
      sb_tail[s] = 0;
      sb_beat[s] = 0;
    end
    foreach (pend_cnt[m]) begin
      ar_head[m]   = 0;
      ar_tail[m]   = 0;
      rd_head[m]   = 0;
      rd_tail[m]   = 0;
      pend_head[m] = 0;
      pend_cnt[m]  = 0;
      mdl_beat[m]  = 0;
      peak[m]      = 0;
    end
    $readmemh("sim/axi_id_serialize_vectors.txt", vec_mem);
    load_ok = 1'b1;
    for (int v = 0; v < num_vectors; v++) begin
      if ($isunknown(vec_mem[4*v+3]) || vec_mst(v) != vec_id(v) % num_ids) begin
        load_ok = 1'b0;
      end
    end
    if (!load_ok) begin
      $display("Vector file is missing, short or has a wrong expected master ID");
    end

    for (int c = 0; c < 4; c++) begin
      @(posedge clk_i);
      #1;
      check_idle("during reset");
    end
    rst_n_i = 1'b1;
    @(negedge clk_i);
    check_idle("after reset");
    report_test(t_reset);

    while (load_ok && !timed_out && done_cnt < num_vectors) begin
      @(negedge clk_i);
      monitor_edge();
      if (cycle == hold_cycles) begin
        reached = 1'b0;
        foreach (peak[m]) reached |= (peak[m] == max_txns);
        if (!reached) begin
          $display("No lane reached %0d outstanding reads while responses were held", max_txns);
          err_cnt[t_limit]++;
        end
      end
      @(posedge clk_i);
      #1;
      cycle++;
      drive_inputs();
      timed_out = (cycle >= max_cycles);
    end
    if (timed_out) begin
      $display("Timeout after %0d cycles with %0d of %0d bursts complete", cycle, done_cnt,
               num_vectors);
    end

    for (int t = 1; t < 6; t++) begin
      report_test(t);
    end
    n_fail = 0;
    foreach (err_cnt[t]) n_fail += (err_cnt[t] != 0) ? 1 : 0;
    $display("Tests passed: %0d, failed: %0d", 6 - n_fail, n_fail);
    if (n_fail == 0 && load_ok && !timed_out) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- sim/axi_id_serialize_vectors.txt
// Columns in hex: slave ID, address, len (beats minus one), expected master ID
// Expected master ID is the slave ID modulo the lane count of 4
05 00001000 03 1
09 00002000 00 1
10 00003000 02 0
0d 00004000 01 1
22 00005000 04 2
01 00006000 00 1
3f 00007000 07 3
15 00008000 02 1
04 00009000 01 0
2b 0000a000 03 3
08 0000b000 00 0
1e 0000c000 05 2
05 0000d000 02 1
33 0000e000 01 3
0c 0000f000 06 0
26 00010000 00 2
11 00011000 03 1
3a 00012000 02 2
07 00013000 01 3
20 00014000 04 0
2d 00015000 00 1
16 00016000 03 2
0f 00017000 02 3
18 00018000 01 0
39 00019000 05 1
2e 0001a000 00 2

//--- filelist.f
src/axi_id_ser_pkg.sv
src/ar_lane_demux.sv
src/ar_id_serializer.sv
src/ar_lane_mux.sv
src/axi_id_serialize_rd.sv
sim/tb_axi_id_serialize.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the AXI ID serializer testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=tb_axi_id_serialize

rm -rf obj_dir

verilator --binary --timing -Wno-fatal --top-module tb_axi_id_serialize \
  -f filelist.f -o "$BIN"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
  exit 1
fi
exit 0
